// ==== spiSubsys.f ====
logic/spiPkg.sv
logic/spiCsr.sv
logic/spiMaster.sv
logic/spiSubsys.sv
verif/spiSubsys_assert.sv
verif/spiSubsysTb.sv

// ==== verif/spiSubsysTb.sv ====
// SPI master block testbench
// Register checks over the bus, SPI slave model, table driven transfers
`timescale 1ns/10ps

module spiSubsysTb
	import spiPkg::*;
;

	localparam logic [31:0] lcgSeed = 32'hc63b_afdd;
	localparam int pollLimit = 400;
	localparam int strobeLimit = 8;
	localparam int randRows = 6;
	// Block 00 never selects this block
	localparam logic [busAdrsBits-1:0] idleAdrs = '0;

	logic                   iSysClk;
	logic                   reset;
	logic [busDataBits-1:0] wd;
	logic [busAdrsBits-1:0] adrs;
	logic                   wCke;
	logic [busDataBits-1:0] rd;
	logic                   rdEn;
	logic                   sck;
	logic                   mosi;
	logic                   miso;
	logic                   cs1;
	logic                   cs2;

	// SPI slave model state
	logic [7:0] slaveTx;
	logic [7:0] slaveRx;
	logic [7:0] slaveBits;
	logic       sckPrev;

	// Row is divider, tx byte, reply byte, cs pattern
	logic [33:0] rows[$];
	logic [31:0] lcgState;

	spiSubsys DUT (.*);

	bind spiSubsys spiSubsys_assert chk (
		.iSysClk (iSysClk),
		.reset   (reset),
		.adrs    (adrs),
		.rdEn    (rdEn),
		.busy    (busy),
		.sck     (sck),
		.mosi    (mosi)
	);

	always #50 iSysClk = ~iSysClk;

	//------------------------------------------------------------
	// SPI slave, sampled on the falling system clock
	//------------------------------------------------------------
	always @(negedge iSysClk)
	begin
		sckPrev <= sck;
		// Rise, capture MOSI
		if (sck && !sckPrev)
		begin
			slaveRx   <= {slaveRx[6:0], mosi};
			slaveBits <= slaveBits + 8'd1;
		end
		// Fall, next reply bit
		else if (!sck && sckPrev)
		begin
			slaveTx <= {slaveTx[6:0], 1'b0};
			miso    <= slaveTx[6];
		end
	end

	// Stop at the first bound assertion failure
	always @(negedge iSysClk)
	begin
		if (DUT.chk.assertFails != 0)
		begin
			$display("A bound assertion on the DUT failed");
			failNow();
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [busAdrsBits-1:0] regAdrs(input logic [7:0] blk,
		input logic [7:0] ofs);
		return {16'h0000, blk, ofs};
	endfunction

	task automatic failNow();
		$display("Test failures found");
		$fatal(1);
	endtask

	//------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------
	task automatic wordCheck(input logic [busDataBits-1:0] got,
		input logic [busDataBits-1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			failNow();
		end
	endtask

	task automatic byteCheck(input logic [7:0] got, input logic [7:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			failNow();
		end
	endtask

	task automatic levelCheck(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			failNow();
		end
	endtask

	//------------------------------------------------------------
	// Bus access, entered and left on a falling edge
	//------------------------------------------------------------
	task automatic busWrite(input logic [7:0] ofs, input logic [busDataBits-1:0] data);
		adrs = regAdrs(blockId, ofs);
		wd   = data;
		wCke = 1'b1;
		@(negedge iSysClk);
		wCke = 1'b0;
		adrs = idleAdrs;
	endtask

	task automatic busRead(input logic [7:0] ofs, output logic [busDataBits-1:0] data);
		int waitCnt;
		waitCnt = 0;
		adrs = regAdrs(blockId, ofs);
		@(negedge iSysClk);
		while (!rdEn)
		begin
			waitCnt++;
			if (waitCnt > strobeLimit)
			begin
				$display("Timeout: no read strobe for offset %h", ofs);
				failNow();
			end
			@(negedge iSysClk);
		end
		data = rd;
		adrs = idleAdrs;
	endtask

	task automatic readExpect(input logic [7:0] ofs, input logic [busDataBits-1:0] exp,
		input string what);
		logic [busDataBits-1:0] val;
		busRead(ofs, val);
		wordCheck(val, exp, what);
	endtask

	// Poll the busy register, pins checked on every poll
	task automatic waitBusy(input logic level, input logic [1:0] csPat);
		logic [busDataBits-1:0] val;
		int polls;
		polls = 0;
		busRead(regBusyOfs, val);
		while (val[0] !== level)
		begin
			levelCheck(cs1, csPat[0], "cs1 pin");
			levelCheck(cs2, csPat[1], "cs2 pin");
			polls++;
			if (polls > pollLimit)
			begin
				$display("Timeout: busy never reached %0d", level);
				failNow();
			end
			busRead(regBusyOfs, val);
		end
	endtask

	task automatic slaveLoad(input logic [7:0] reply);
		slaveTx   = reply;
		miso      = reply[7];
		slaveRx   = 8'h00;
		slaveBits = 8'h00;
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		logic [busDataBits-1:0] val;
		logic [15:0] div;
		logic [7:0]  txv;
		logic [7:0]  rep;
		logic [1:0]  csPat;
		iSysClk = 1'b0;
		reset   = 1'b1;
		wd      = '0;
		adrs    = idleAdrs;
		wCke    = 1'b0;
		miso    = 1'b0;
		sckPrev = 1'b0;
		slaveLoad(8'h00);
		lcgState = lcgSeed;
		// Fixed corners first
		rows.push_back({16'd0, 8'ha5, 8'h3c, 2'b10});
		rows.push_back({16'd1, 8'h81, 8'h7e, 2'b01});
		rows.push_back({16'd3, 8'hff, 8'h00, 2'b00});
		rows.push_back({16'd2, 8'h00, 8'hff, 2'b11});
		// Random rows, divider kept small
		for (int i = 0; i < randRows; i++)
		begin
			lcgState = lcgNext(lcgState);
			rows.push_back({13'd0, lcgState[30:28], lcgState[23:16], lcgState[15:8],
				lcgState[27:26]});
		end
		repeat (16) @(negedge iSysClk);
		reset = 1'b0;

		// Reset values
		readExpect(regEnOfs, 32'h0, "enable after reset");
		readExpect(regDivOfs, 32'h0000_ffff, "divider after reset");
		readExpect(regTxOfs, 32'h0, "tx byte after reset");
		readExpect(regCsOfs, 32'h3, "chip selects after reset");
		readExpect(regRxOfs, 32'h0, "rx byte after reset");
		readExpect(regBusyOfs, 32'h0, "busy after reset");

		// Holes in the map
		readExpect(8'h10, 32'h0, "unmapped offset 10");
		readExpect(8'h40, 32'h0, "unmapped offset 40");
		readExpect(8'hfc, 32'h0, "unmapped offset fc");
		// Foreign block gives no strobe
		adrs = regAdrs(8'h04, regEnOfs);
		repeat (4)
		begin
			@(negedge iSysClk);
			levelCheck(rdEn, 1'b0, "rdEn for foreign block");
		end
		adrs = idleAdrs;

		// Writes that must be dropped
		adrs = regAdrs(blockId, regTxOfs);
		wd   = 32'h5a;
		@(negedge iSysClk);
		adrs = regAdrs(8'h04, regTxOfs);
		wCke = 1'b1;
		@(negedge iSysClk);
		wCke = 1'b0;
		adrs = idleAdrs;
		readExpect(regTxOfs, 32'h0, "tx byte after dropped writes");

		for (int i = 0; i < rows.size(); i++)
		begin
			{div, txv, rep, csPat} = rows[i];
			busWrite(regDivOfs, busDataBits'(div));
			busWrite(regTxOfs, busDataBits'(txv));
			busWrite(regCsOfs, busDataBits'(csPat));
			readExpect(regDivOfs, busDataBits'(div), "divider readback");
			readExpect(regTxOfs, busDataBits'(txv), "tx byte readback");
			readExpect(regCsOfs, busDataBits'(csPat), "chip select readback");

			// One transfer
			slaveLoad(rep);
			busWrite(regEnOfs, 32'h1);
			waitBusy(1'b1, csPat);
			waitBusy(1'b0, csPat);
			byteCheck(slaveRx, txv, "byte seen by slave");
			byteCheck(slaveBits, 8'd8, "sck rising edges");
			readExpect(regRxOfs, busDataBits'(rep), "rx byte register");
			readExpect(regEnOfs, 32'h1, "enable readback");

			// Enable still set, no new edge
			if (i == 0)
			begin
				slaveLoad(8'h00);
				busWrite(regEnOfs, 32'h1);
				repeat (4)
				begin
					busRead(regBusyOfs, val);
					wordCheck(val, 32'h0, "busy after repeated enable");
				end
				byteCheck(slaveBits, 8'd0, "sck edges after repeated enable");
			end
			busWrite(regEnOfs, 32'h0);
		end

		if (DUT.chk.assertFails == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("Bound assertions reported failures");
			failNow();
		end
	end

endmodule

// ==== verif/spiSubsys_assert.sv ====
// SPI block protocol checks
// Bound to the top level, watches the read strobe, busy and SPI pins
`timescale 1ns/10ps

module spiSubsys_assert
	import spiPkg::*;
(
	input logic                   iSysClk,
	input logic                   reset,
	input logic [busAdrsBits-1:0] adrs,
	input logic                   rdEn,
	input logic                   busy,
	input logic                   sck,
	input logic                   mosi
);

	// Failure count, watched by the testbench
	int assertFails = 0;

	logic inBlock;

	assign inBlock = (adrs[8 +: blockMapBits] == blockId);

	//------------------------------------------------------------
	// Read strobe
	//------------------------------------------------------------
	// Two strobes in a row need two selected cycles
	rdEnBackToBack: assert property (@(posedge iSysClk) disable iff (reset)
		rdEn && $past(rdEn) |-> $past(inBlock) && $past(inBlock, 2))
	else
	begin
		assertFails++;
		$error("rdEn high twice without the address staying in the block");
	end

	//------------------------------------------------------------
	// SPI pins
	//------------------------------------------------------------
	// SCK idles low outside a transfer
	sckIdleLow: assert property (@(posedge iSysClk) disable iff (reset)
		!busy |-> !sck)
	else
	begin
		assertFails++;
		$error("sck high while busy is low");
	end

	// MOSI only moves while SCK is low
	mosiStable: assert property (@(posedge iSysClk) disable iff (reset)
		sck |-> $stable(mosi))
	else
	begin
		assertFails++;
		$error("mosi changed while sck was high");
	end

endmodule

// ==== logic/spiSubsys.sv ====
// SPI master block top level
// Joins the register file and the transfer engine to bus and SPI pins
`timescale 1ns/10ps

module spiSubsys
	import spiPkg::*;
(
	// Clock and reset
	input  logic                   iSysClk,
	input  logic                   reset,
	// System bus
	input  logic [busDataBits-1:0] wd,
	input  logic [busAdrsBits-1:0] adrs,
	input  logic                   wCke,
	output logic [busDataBits-1:0] rd,
	output logic                   rdEn,
	// SPI pins
	output logic                   sck,
	output logic                   mosi,
	input  logic                   miso,
	output logic                   cs1,
	output logic                   cs2
);

	// Register file to engine
	logic               spiEn;
	logic [divBits-1:0] spiDiv;
	logic [7:0]         txByte;
	// Engine back to register file
	logic               busy;
	logic [7:0]         rxByte;

	//----------------------------------------------------------
	// Register file, chip selects go straight to the pins
	//----------------------------------------------------------
	spiCsr csr (
		.iSysClk (iSysClk),
		.reset   (reset),
		.wd      (wd),
		.adrs    (adrs),
		.wCke    (wCke),
		.rd      (rd),
		.rdEn    (rdEn),
		.rxByte  (rxByte),
		.busy    (busy),
		.spiEn   (spiEn),
		.spiDiv  (spiDiv),
		.txByte  (txByte),
		.cs1     (cs1),
		.cs2     (cs2)
	);

	//----------------------------------------------------------
	// Transfer engine
	//----------------------------------------------------------
	spiMaster master (
		.iSysClk (iSysClk),
		.reset   (reset),
		.spiEn   (spiEn),
		.spiDiv  (spiDiv),
		.txByte  (txByte),
		.busy    (busy),
		.rxByte  (rxByte),
		.sck     (sck),
		.mosi    (mosi),
		.miso    (miso)
	);

endmodule

// ==== logic/spiMaster.sv ====
// SPI mode-0 transfer engine
// One 8-bit MSB-first transfer per rising edge of the enable bit
// SCK half period is spiDiv+1 system clocks
`timescale 1ns/10ps

module spiMaster
	import spiPkg::*;
(
	// Clock and reset
	input  logic               iSysClk,
	input  logic               reset,
	// Control from the register file
	input  logic               spiEn,
	input  logic [divBits-1:0] spiDiv,
	input  logic [7:0]         txByte,
	// Status to the register file
	output logic               busy,
	output logic [7:0]         rxByte,
	// SPI pins
	output logic               sck,
	output logic               mosi,
	input  logic               miso
);

	logic               enPrev;
	logic               enRise;
	logic               start;
	logic [divBits-1:0] divLatch;
	logic [divBits-1:0] divCnt;
	logic               halfEnd;
	logic [3:0]         halfCnt;
	logic               lastHalf;
	logic               riseTick;
	logic               fallTick;
	logic [7:0]         txShift;
	logic [7:0]         rxShift;

	//----------------------------------------------------------
	// Start detect
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			enPrev <= 1'b0;
		else
			enPrev <= spiEn;
	end

	assign enRise = spiEn & ~enPrev;
	// Edges during a transfer are lost, software re-arms by clearing
	assign start  = enRise & ~busy;

	//----------------------------------------------------------
	// Half period timing
	//----------------------------------------------------------
	// Last clock of the current half period
	assign halfEnd  = busy & (divCnt == divLatch);
	// Sixteenth half, SCK high
	assign lastHalf = (halfCnt == 4'd15);
	// SCK about to rise or fall
	assign riseTick = halfEnd & ~sck;
	assign fallTick = halfEnd & sck;

	// Divider captured once per transfer
	always_ff @(posedge iSysClk)
	begin
		if (start)
			divLatch <= spiDiv;
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			divCnt  <= '0;
			halfCnt <= 4'd0;
		end
		else if (start)
		begin
			divCnt  <= '0;
			halfCnt <= 4'd0;
		end
		else if (halfEnd)
		begin
			divCnt  <= '0;
			halfCnt <= halfCnt + 4'd1;
		end
		else if (busy)
			divCnt <= divCnt + 1'b1;
	end

	// Busy and SCK, idle low
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			sck  <= 1'b0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			sck  <= 1'b0;
		end
		else if (halfEnd)
		begin
			// Final toggle brings SCK back low
			sck <= ~sck;
			if (lastHalf)
				busy <= 1'b0;
		end
	end

	//----------------------------------------------------------
	// Data path
	//----------------------------------------------------------
	// Transmit shifts on falls, receive samples on rises
	always_ff @(posedge iSysClk)
	begin
		if (start)
			txShift <= txByte;
		else if (fallTick)
			txShift <= {txShift[6:0], 1'b0};
		if (riseTick)
			rxShift <= {rxShift[6:0], miso};
	end

	// First bit valid before the first rise
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			mosi <= 1'b0;
		else if (start)
			mosi <= txByte[7];
		else if (fallTick)
			mosi <= lastHalf ? 1'b0 : txShift[6];
	end

	// Received byte lands with the fall of busy
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			rxByte <= 8'h00;
		else if (fallTick && lastHalf)
			rxByte <= rxShift;
	end

endmodule

// ==== logic/spiCsr.sv ====
// SPI master register file
// Decodes bus writes into enable, divider, transmit byte and chip selects
// Answers reads through a registered mux with a one-cycle read strobe
`timescale 1ns/10ps

module spiCsr
	import spiPkg::*;
(
	// Clock and reset
	input  logic                   iSysClk,
	input  logic                   reset,
	// Bus write side
	input  logic [busDataBits-1:0] wd,
	input  logic [busAdrsBits-1:0] adrs,
	input  logic                   wCke,
	// Bus read side
	output logic [busDataBits-1:0] rd,
	output logic                   rdEn,
	// Status from the engine
	input  logic [7:0]             rxByte,
	input  logic                   busy,
	// Control to the engine
	output logic                   spiEn,
	output logic [divBits-1:0]     spiDiv,
	output logic [7:0]             txByte,
	// Chip select pins
	output logic                   cs1,
	output logic                   cs2
);

	logic                   blockHit;
	logic                   wrHit;
	logic [7:0]             ofs;
	logic [7:0]             rxByteQ;
	logic                   busyQ;
	logic [busDataBits-1:0] rdNext;

	//----------------------------------------------------------
	// Address decode
	//----------------------------------------------------------
	// Block select sits right above the offset byte
	assign blockHit = (adrs[8 +: blockMapBits] == blockId);
	// Write needs both strobe and select
	assign wrHit    = wCke & blockHit;
	assign ofs      = adrs[7:0];

	//----------------------------------------------------------
	// Control registers
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			spiEn  <= 1'b0;
			spiDiv <= divResetVal;
			txByte <= 8'h00;
			cs1    <= csResetVal[0];
			cs2    <= csResetVal[1];
		end
		else if (wrHit)
		begin
			case (ofs)
				// Engine starts on a 0 to 1 change of this bit
				regEnOfs:  spiEn  <= wd[0];
				regDivOfs: spiDiv <= wd[divBits-1:0];
				regTxOfs:  txByte <= wd[7:0];
				// Bit 0 drives cs1, bit 1 drives cs2
				regCsOfs:
				begin
					cs1 <= wd[0];
					cs2 <= wd[1];
				end
				// Status and unmapped offsets drop the write
				default: ;
			endcase
		end
	end

	// Status copies from the engine
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			rxByteQ <= 8'h00;
			busyQ   <= 1'b0;
		end
		else
		begin
			rxByteQ <= rxByte;
			busyQ   <= busy;
		end
	end

	//----------------------------------------------------------
	// Read mux
	//----------------------------------------------------------
	// Every register zero-extended to the bus word
	always_comb
	begin
		case (ofs)
			regEnOfs:   rdNext = busDataBits'(spiEn);
			regDivOfs:  rdNext = busDataBits'(spiDiv);
			regTxOfs:   rdNext = busDataBits'(txByte);
			regCsOfs:   rdNext = busDataBits'({cs2, cs1});
			regRxOfs:   rdNext = busDataBits'(rxByteQ);
			regBusyOfs: rdNext = busDataBits'(busyQ);
			// Holes in the map read as zero
			default:    rdNext = '0;
		endcase
	end

	// Strobe follows every selected cycle
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			rdEn <= 1'b0;
		else
			rdEn <= blockHit;
	end

	// Data word only moves for this block
	always_ff @(posedge iSysClk)
	begin
		if (blockHit)
			rd <= rdNext;
	end

endmodule

// ==== logic/spiPkg.sv ====
// SPI master block shared definitions
// Bus widths, block map, register offsets and reset values

package spiPkg;

	//----------------------------------------------------------
	// System bus
	//----------------------------------------------------------
	localparam int busAdrsBits = 32;
	localparam int busDataBits = 32;

	// Block select field, address bits 15..8
	localparam int blockMapBits = 8;
	localparam logic [blockMapBits-1:0] blockId = 8'h03;

	//----------------------------------------------------------
	// Engine sizing
	//----------------------------------------------------------
	// Half period counter width
	localparam int divBits = 16;

	//----------------------------------------------------------
	// Register offsets, address bits 7..0
	//----------------------------------------------------------
	// Read/write control
	localparam logic [7:0] regEnOfs   = 8'h00;
	localparam logic [7:0] regDivOfs  = 8'h04;
	localparam logic [7:0] regTxOfs   = 8'h08;
	localparam logic [7:0] regCsOfs   = 8'h0c;
	// Read only status
	localparam logic [7:0] regRxOfs   = 8'h80;
	localparam logic [7:0] regBusyOfs = 8'h84;

	//----------------------------------------------------------
	// Reset values
	//----------------------------------------------------------
	// Slowest SCK out of reset
	localparam logic [divBits-1:0] divResetVal = '1;
	// Both chip selects deasserted
	localparam logic [1:0] csResetVal = 2'b11;

endpackage
